// File: scratchpadTop.f
+incdir+include
design/ramPkg.sv
design/ramPortIf.sv
design/multiPortRam.sv
design/apbRamBridge.sv
design/scratchpadTop.sv
verif/scratchpadTop_assert.sv
verif/scratchpadTb.sv

// File: Bender.yml
package:
  name: scratchpad

export_include_dirs:
  - include

sources:
  - design/ramPkg.sv
  - design/ramPortIf.sv
  - design/multiPortRam.sv
  - design/apbRamBridge.sv
  - design/scratchpadTop.sv
  - target: simulation
    files:
      - verif/scratchpadTop_assert.sv
      - verif/scratchpadTb.sv

// File: verif/scratchpadTb.sv
`timescale 1ns/1ps

// testbench for the shared scratchpad
module scratchpadTb
    import ramPkg::*;
();
    localparam int waitLimit = 4 * ramDepth;

    logic clk;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] paddr;
    ramStrobe pstrb;
    ramData pwdata;
    ramData prdata;
    logic pready;
    logic pslverr;
    logic clientEn;
    ramAddr clientAddr;
    ramStrobe clientWe;
    ramData clientWdata;
    ramData clientRdata;
    logic ready;

    logic [31:0] lfsrState = 32'h2c1d_d470;
    int timeoutCount = 0;
    int failTotal;

    scratchpadTop #(
        .WIDTH(dataWidth),
        .DEPTH(ramDepth)
    ) scratchpadTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] nextBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
        end
        return value;
    endfunction

    // one APB transfer with an optional client write to the same word
    task automatic apbTransfer(input logic write, input logic [31:0] addr, input ramData data,
                               input ramStrobe strb, input logic clash);
        int waited;
        waited = 0;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pstrb <= strb;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        if (clash) begin
            clientAddr <= ramAddr'(addr[31:2]);
            clientWe <= ramStrobe'(nextBits(byteLanes));
            clientWdata <= ramData'(nextBits(dataWidth));
        end
        // pready sampled mid-cycle
        @(negedge clk);
        while (!pready && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            timeoutCount++;
            $display("timeout at %0t, pready never rose for address %h", $time, addr);
        end
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
        clientWe <= '0;
    endtask

    // one cycle of client pins
    task automatic clientCycle(input logic en, input ramAddr addr, input ramStrobe we,
                               input ramData data);
        @(posedge clk);
        clientEn <= en;
        clientAddr <= addr;
        clientWe <= we;
        clientWdata <= data;
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        while (!ready && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            timeoutCount++;
            $display("timeout at %0t, ready never rose after reset", $time);
        end
    endtask

    initial begin
        logic [31:0] addr;
        ramAddr word;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pstrb = '0;
        pwdata = '0;
        clientEn = 1'b0;
        clientAddr = '0;
        clientWe = '0;
        clientWdata = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // client writes during the sweep are dropped
        repeat (ramDepth / 2) begin
            clientCycle(1'b1, ramAddr'(nextBits(addrWidth)), ramStrobe'(nextBits(byteLanes)),
                ramData'(nextBits(dataWidth)));
        end
        clientCycle(1'b0, '0, '0, '0);
        // host read stalls until ready
        apbTransfer(1'b0, 32'h0, '0, '0, 1'b0);
        waitReady();
        // all words cleared
        for (int i = 0; i < ramDepth; i++) begin
            apbTransfer(1'b0, 32'(i * 4), '0, '0, 1'b0);
            clientCycle(1'b1, ramAddr'(i), '0, '0);
            clientCycle(1'b0, '0, '0, '0);
        end
        // host write with random strobes then read back
        repeat (8) begin
            addr = nextBits(addrWidth) << 2;
            apbTransfer(1'b1, addr, ramData'(nextBits(dataWidth)),
                ramStrobe'(nextBits(byteLanes)), 1'b0);
            apbTransfer(1'b0, addr, '0, '0, 1'b0);
        end
        // client write seen by host and host write seen by client
        repeat (4) begin
            word = ramAddr'(nextBits(addrWidth));
            clientCycle(1'b0, word, '1, ramData'(nextBits(dataWidth)));
            clientCycle(1'b0, '0, '0, '0);
            apbTransfer(1'b0, 32'(word) << 2, '0, '0, 1'b0);
            apbTransfer(1'b1, 32'(word) << 2, ramData'(nextBits(dataWidth)), '1, 1'b0);
            clientCycle(1'b1, word, '0, '0);
            clientCycle(1'b0, '0, '0, '0);
        end
        // both ports write one word in the same cycle
        repeat (6) begin
            addr = nextBits(addrWidth) << 2;
            apbTransfer(1'b1, addr, ramData'(nextBits(dataWidth)),
                ramStrobe'(nextBits(byteLanes)), 1'b1);
            apbTransfer(1'b0, addr, '0, '0, 1'b0);
        end
        // out of range and misaligned accesses leave memory untouched
        apbTransfer(1'b1, 32'(ramDepth * 4), '1, '1, 1'b0);
        apbTransfer(1'b1, 32'h6, '1, '1, 1'b0);
        apbTransfer(1'b0, 32'(ramDepth * 4 + 8), '0, '0, 1'b0);
        apbTransfer(1'b0, 32'h0, '0, '0, 1'b0);
        apbTransfer(1'b0, 32'h4, '0, '0, 1'b0);
        // back to back random client traffic
        repeat (64) begin
            clientCycle(1'b1, ramAddr'(nextBits(addrWidth)), ramStrobe'(nextBits(byteLanes)),
                ramData'(nextBits(dataWidth)));
        end
        clientCycle(1'b0, '0, '0, '0);
        repeat (2) @(posedge clk);
        failTotal = scratchpadTop_inst.assertInst.failCount;
        $display("assertion failures %0d, timeouts %0d", failTotal, timeoutCount);
        if (failTotal == 0 && timeoutCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verif/scratchpadTop_assert.sv
`timescale 1ns/1ps
`include "ramDefines.svh"

// shadow memory and port checks bound into scratchpadTop
module scratchpadAssert
    import ramPkg::*;
#(
    parameter int DEPTH = ramDepth
)(
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic `N(32) paddr,
    input ramStrobe pstrb,
    input ramData pwdata,
    input ramData prdata,
    input logic pready,
    input logic pslverr,
    input logic clientEn,
    input ramAddr clientAddr,
    input ramStrobe clientWe,
    input ramData clientWdata,
    input ramData clientRdata,
    input logic ready
);
    localparam int ADDR_WIDTH = $clog2(DEPTH);

    ramData shadow [DEPTH];
    int sweepCycles;
    ramData hostExp;
    ramData clientExp;
    logic hostPending;
    logic clientPending;
    logic badAddr;
    logic hostWrite;
    logic hostRead;
    int failCount = 0;

    // misaligned or past the last word
    assign badAddr = (paddr[1:0] != 2'b00) || (paddr[31:2] >= DEPTH);
    assign hostWrite = psel && penable && pwrite && ready && !badAddr;
    // first access cycle of a good read
    assign hostRead = psel && penable && !pwrite && ready && !badAddr && !hostPending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst == `RST) begin
            sweepCycles <= 0;
            hostPending <= 1'b0;
            clientPending <= 1'b0;
            hostExp <= '0;
            clientExp <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (sweepCycles < DEPTH + 1) begin
                sweepCycles <= sweepCycles + 1;
            end
            // reads return the word from before same-cycle writes
            hostPending <= hostRead;
            hostExp <= shadow[paddr[ADDR_WIDTH+1:2]];
            clientPending <= clientEn;
            clientExp <= (ready && clientAddr < DEPTH) ? shadow[clientAddr] : '0;
            if (ready) begin
                for (int j = 0; j < byteLanes; j++) begin
                    if (hostWrite && pstrb[j]) begin
                        shadow[paddr[ADDR_WIDTH+1:2]][j] <= pwdata[j];
                    end
                    // client lane overrides the host lane
                    if (clientWe[j] && clientAddr < DEPTH) begin
                        shadow[clientAddr][j] <= clientWdata[j];
                    end
                end
            end
        end
    end

    // ready rises DEPTH+1 cycles after release and stays high
    readySweep: assert property (@(posedge clk) disable iff (rst)
        ready == (sweepCycles == DEPTH + 1))
        else begin
            $error("error at %0t: ready expected %b got %b", $time,
                $sampled(sweepCycles == DEPTH + 1), $sampled(ready));
            failCount++;
        end

    // no host completion during the sweep
    backPressure: assert property (@(posedge clk) disable iff (rst) !ready |-> !pready)
        else begin
            $error("error at %0t: pready expected 0 got %b", $time, $sampled(pready));
            failCount++;
        end

    // first access cycle of a read never completes
    readNotEarly: assert property (@(posedge clk) disable iff (rst) hostRead |-> !pready)
        else begin
            $error("error at %0t: pready expected 0 got %b", $time, $sampled(pready));
            failCount++;
        end

    // read ends in the second access cycle with the shadow word
    hostReadData: assert property (@(posedge clk) disable iff (rst)
        hostPending |-> pready && !pslverr && prdata == hostExp)
        else begin
            $error("error at %0t: prdata expected %h got %h, pready %b", $time,
                $sampled(hostExp), $sampled(prdata), $sampled(pready));
            failCount++;
        end

    writeDone: assert property (@(posedge clk) disable iff (rst)
        hostWrite |-> pready && !pslverr)
        else begin
            $error("error at %0t: pready expected 1 got %b", $time, $sampled(pready));
            failCount++;
        end

    errorResponse: assert property (@(posedge clk) disable iff (rst)
        psel && penable && ready && badAddr |-> pready && pslverr && prdata == '0)
        else begin
            $error("error at %0t: pslverr expected 1 got %b, prdata expected 0 got %h",
                $time, $sampled(pslverr), $sampled(prdata));
            failCount++;
        end

    clientReadData: assert property (@(posedge clk) disable iff (rst)
        clientPending |-> clientRdata == clientExp)
        else begin
            $error("error at %0t: clientRdata expected %h got %h", $time,
                $sampled(clientExp), $sampled(clientRdata));
            failCount++;
        end

endmodule

bind scratchpadTop scratchpadAssert #(.DEPTH(DEPTH)) assertInst (.*);

// File: design/scratchpadTop.sv
`timescale 1ns/1ps
`include "ramDefines.svh"

// shared scratchpad
// APB host port and direct client port on one array
module scratchpadTop
    import ramPkg::*;
#(
    parameter int WIDTH = dataWidth,
    parameter int DEPTH = ramDepth
)(
    input logic clk,
    input logic rst,

    // APB host
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic `N(32) paddr,
    input ramStrobe pstrb,
    input ramData pwdata,
    output ramData prdata,
    output logic pready,
    output logic pslverr,

    // processor-side client
    input logic clientEn,
    input ramAddr clientAddr,
    input ramStrobe clientWe,
    input ramData clientWdata,
    output ramData clientRdata,

    // sweep finished
    output logic ready
);

    // host side, driven by the bridge
    ramPortIf #(
        .WIDTH(WIDTH),
        .DEPTH(DEPTH)
    ) hostPort ();

    // client side, driven from the pins
    ramPortIf #(
        .WIDTH(WIDTH),
        .DEPTH(DEPTH)
    ) clientPort ();

    // client pins map one to one
    assign clientPort.en = clientEn;
    assign clientPort.addr = clientAddr;
    assign clientPort.we = clientWe;
    assign clientPort.wdata = clientWdata;
    assign clientRdata = clientPort.rdata;

    apbRamBridge #(
        .WIDTH(WIDTH),
        .DEPTH(DEPTH)
    ) bridge (
        .clk(clk),
        .rst(rst),
        .ready(ready),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pstrb(pstrb),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .mem(hostPort.requester)
    );

    multiPortRam #(
        .WIDTH(WIDTH),
        .DEPTH(DEPTH)
    ) ram (
        .clk(clk),
        .rst(rst),
        .hostPort(hostPort.memory),
        .clientPort(clientPort.memory),
        .ready(ready)
    );

endmodule

// File: design/apbRamBridge.sv
`timescale 1ns/1ps
`include "ramDefines.svh"

// APB slave in front of one memory port
// writes finish in the first access cycle, reads in the second
module apbRamBridge
    import ramPkg::*;
#(
    parameter int WIDTH = dataWidth,
    parameter int DEPTH = ramDepth
)(
    input logic clk,
    input logic rst,
    input logic ready,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic `N(32) paddr,
    input ramStrobe pstrb,
    input ramData pwdata,
    output ramData prdata,
    output logic pready,
    output logic pslverr,
    ramPortIf.requester mem
);
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam int BYTES = WIDTH / 8;

    typedef enum logic {
        idle,
        readWait
    } bridgeState;

    bridgeState state;

    // byte address with the lane bits dropped
    logic `N(30) wordIndex;
    logic badAddr;
    logic access;
    logic readIssue;
    logic writeIssue;

    assign wordIndex = paddr[31:2];

    // misaligned or past the last word
    assign badAddr = (paddr[1:0] != 2'b00) || (wordIndex >= DEPTH);

    // first access cycle, held off until the sweep is done
    assign access = psel && penable && ready && (state == idle);
    assign readIssue = access && !pwrite && !badAddr;
    assign writeIssue = access && pwrite && !badAddr;

    // one memory access per transfer
    assign mem.en = readIssue;
    assign mem.addr = wordIndex[ADDR_WIDTH-1:0];
    // strobes straight onto the lane enables
    assign mem.we = pstrb & {BYTES{writeIssue}};
    assign mem.wdata = pwdata;

    // writes and errors complete at once, reads one cycle later
    assign pready = (state == readWait) || (access && (pwrite || badAddr));
    assign pslverr = access && badAddr;
    assign prdata = (state == readWait) ? mem.rdata : '0;

    // read completion FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst == `RST) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (readIssue) begin
                        state <= readWait;
                    end
                end
                readWait: begin
                    // rdata is valid now, transfer ends
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

// File: design/multiPortRam.sv
`timescale 1ns/1ps
`include "ramDefines.svh"

// two-port word array
// reset sweep, byte writes, registered reads
module multiPortRam
    import ramPkg::*;
#(
    parameter int WIDTH = dataWidth,
    parameter int DEPTH = ramDepth
)(
    input logic clk,
    input logic rst,
    ramPortIf.memory hostPort,
    ramPortIf.memory clientPort,
    output logic ready
);
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam int BYTES = WIDTH / 8;

    // storage, lane-addressable
    logic `ARRAY(BYTES, 8) mem `N(DEPTH);

    // one extra bit so the count can reach DEPTH
    logic `N(ADDR_WIDTH+1) sweepCount;

    // port address inside the array
    logic hostHit;
    logic clientHit;

    assign hostHit = hostPort.addr < DEPTH;
    assign clientHit = clientPort.addr < DEPTH;

    // word fetch, zero outside the array
    function automatic logic `ARRAY(BYTES, 8) readWord(input logic `N(ADDR_WIDTH) addr);
        logic `ARRAY(BYTES, 8) word;
        word = '0;
        if (addr < DEPTH) begin
            word = mem[addr];
        end
        return word;
    endfunction

    // sweep counter
    // one word per cycle, ready one cycle after the last word
    always_ff @(posedge clk or posedge rst) begin
        if (rst == `RST) begin
            sweepCount <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            sweepCount <= sweepCount + 1'b1;
            if (sweepCount == DEPTH) begin
                ready <= 1'b1;
            end
        end
    end

    // write path
    always_ff @(posedge clk) begin
        if (!ready) begin
            // clear phase, port writes dropped
            if (sweepCount < DEPTH) begin
                mem[sweepCount[ADDR_WIDTH-1:0]] <= '0;
            end
        end else begin
            for (int j = 0; j < BYTES; j++) begin
                // host lane first
                if (hostPort.we[j] && hostHit) begin
                    mem[hostPort.addr][j] <= hostPort.wdata[j];
                end
                // client lane last, so it wins on the same word
                if (clientPort.we[j] && clientHit) begin
                    mem[clientPort.addr][j] <= clientPort.wdata[j];
                end
            end
        end
    end

    // read paths, one register per port
    // same-cycle write is not visible, old word comes back
    always_ff @(posedge clk or posedge rst) begin
        if (rst == `RST) begin
            hostPort.rdata <= '0;
            clientPort.rdata <= '0;
        end else if (!ready) begin
            // held at zero during the sweep
            hostPort.rdata <= '0;
            clientPort.rdata <= '0;
        end else begin
            if (hostPort.en) begin
                hostPort.rdata <= readWord(hostPort.addr);
            end
            if (clientPort.en) begin
                clientPort.rdata <= readWord(clientPort.addr);
            end
        end
    end

endmodule

// File: design/ramPortIf.sv
`timescale 1ns/1ps
`include "ramDefines.svh"

// one access port into the word array
// no handshake, read data one cycle after en
interface ramPortIf
    import ramPkg::*;
#(
    parameter int WIDTH = dataWidth,
    parameter int DEPTH = ramDepth
);
    localparam int ADDR_WIDTH = $clog2(DEPTH);
    localparam int BYTES = WIDTH / 8;

    // read request
    logic en;
    logic `N(ADDR_WIDTH) addr;
    // byte strobe, any bit set means write
    logic `N(BYTES) we;
    logic `ARRAY(BYTES, 8) wdata;
    logic `ARRAY(BYTES, 8) rdata;

    // bridge or client side
    modport requester (output en, addr, we, wdata, input rdata);

    // array side
    modport memory (input en, addr, we, wdata, output rdata);

endinterface

// File: design/ramPkg.sv
`include "ramDefines.svh"

// shared sizes and types for the scratchpad
package ramPkg;

    // one memory word
    localparam int dataWidth = 32;

    // words in the array
    localparam int ramDepth = 16;

    // word index width
    localparam int addrWidth = $clog2(ramDepth);

    // byte lanes per word
    localparam int byteLanes = dataWidth / 8;

    // word index
    typedef logic `N(addrWidth) ramAddr;

    // word split into byte lanes
    typedef logic `ARRAY(byteLanes, 8) ramData;

    // one write enable per lane
    typedef logic `N(byteLanes) ramStrobe;

endpackage

// File: include/ramDefines.svh
`ifndef RAM_DEFINES_SVH
`define RAM_DEFINES_SVH

// packed vector of n bits
`define N(n) [(n)-1:0]

// two-level packed array, h rows of w bits
`define ARRAY(h, w) [(h)-1:0][(w)-1:0]

// asserted reset level
`define RST 1'b1

`endif
